// ==== hw/i2c_wb_consts.svh ====
`ifndef I2C_WB_CONSTS_SVH
`define I2C_WB_CONSTS_SVH

// register word addresses
`define I2C_ADDR_CONTROL       32'd0
`define I2C_ADDR_STATUS        32'd1
`define I2C_ADDR_CLOCK_RATE    32'd2
`define I2C_ADDR_CLOCK_DIVIDER 32'd3
`define I2C_ADDR_COMMAND       32'd4
`define I2C_ADDR_TRANSMIT      32'd5
`define I2C_ADDR_RECEIVE       32'd6

// core clock, 250 MHz
`define I2C_CLOCK_RATE         32'd250_000_000

// quarter-phase length minus one, four quarters per SCL period
`define I2C_CLK_DIVIDE_100KHZ  16'd624
`define I2C_CLK_DIVIDE_400KHZ  16'd155

`define I2C_CONTROL_RESET      8'h01

`endif

// ==== hw/i2c_wb_pkg.sv ====
package i2c_wb_pkg;

  // command register, low five bits
  typedef struct packed {
    logic ack;
    logic write;
    logic read;
    logic stop;
    logic start;
  } i2c_cmd_t;

  // control register
  typedef struct packed {
    logic       soft_reset;
    logic [2:0] reserved;
    logic       set_400khz;
    logic       set_100khz;
    logic       ien;
    logic       core_en;
  } i2c_ctrl_t;

  // status register
  typedef struct packed {
    logic       rxack;
    logic       busy;
    logic       al;
    logic [2:0] reserved;
    logic       tip;
    logic       irq_flag;
  } i2c_status_t;

  // single bit-level operations on the bus
  typedef enum logic [2:0] {
    BIT_IDLE  = 3'd0,
    BIT_START = 3'd1,
    BIT_STOP  = 3'd2,
    BIT_WRITE = 3'd3,
    BIT_READ  = 3'd4
  } i2c_bit_cmd_e;

endpackage

// ==== hw/i2c_wb_if.sv ====
`timescale 1ns/1ps

// register block to byte controller
interface i2c_cmd_if;
  i2c_wb_pkg::i2c_cmd_t cmd;
  logic [7:0]           tx_byte;
  logic [15:0]          divider;
  logic                 core_en;
  logic                 soft_reset;
  logic                 done;
  logic                 rx_ack;
  logic [7:0]           rx_byte;
  logic                 busy;
  logic                 al;

  modport master (output cmd, tx_byte, divider, core_en, soft_reset,
                  input  done, rx_ack, rx_byte, busy, al);
  modport slave  (input  cmd, tx_byte, divider, core_en, soft_reset,
                  output done, rx_ack, rx_byte, busy, al);
endinterface

// byte controller to bit controller
interface i2c_bit_if;
  i2c_wb_pkg::i2c_bit_cmd_e bit_cmd;
  logic                     bit_din;
  logic [15:0]              divider;
  logic                     soft_reset;
  logic                     bit_ack;
  logic                     bit_dout;
  logic                     busy;
  logic                     al;

  modport master (output bit_cmd, bit_din, divider, soft_reset,
                  input  bit_ack, bit_dout, busy, al);
  modport slave  (input  bit_cmd, bit_din, divider, soft_reset,
                  output bit_ack, bit_dout, busy, al);
endinterface

// ==== hw/i2c_wb_regs.sv ====
`timescale 1ns/1ps
`include "i2c_wb_consts.svh"

module i2c_wb_regs (
  input  logic        clk,
  input  logic        core_reset,
  input  logic        i_wb_cyc,
  input  logic        i_wb_stb,
  input  logic        i_wb_we,
  input  logic [31:0] i_wb_adr,
  input  logic [31:0] i_wb_dat,
  output logic [31:0] o_wb_dat,
  output logic        o_wb_ack,
  output logic        o_int,
  i2c_cmd_if.master   cmd_bus
);

  i2c_wb_pkg::i2c_ctrl_t   ctrl;
  i2c_wb_pkg::i2c_cmd_t    cmd;
  i2c_wb_pkg::i2c_status_t status;
  logic [15:0]             divider;
  logic [7:0]              tx_byte;
  logic                    rxack;
  logic                    tip;
  logic                    irq_flag;
  logic                    al_seen;
  logic                    wb_req;
  logic                    wb_wr;

  // new access, not yet acknowledged
  assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
  assign wb_wr  = wb_req & i_wb_we;

  always_ff @(posedge clk) begin
    if (core_reset) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= wb_req;
    end
  end

  // read data, captured with the strobe
  always_ff @(posedge clk) begin
    if (wb_req && !i_wb_we) begin
      case (i_wb_adr)
        `I2C_ADDR_CONTROL:       o_wb_dat <= {24'h0, ctrl};
        `I2C_ADDR_STATUS:        o_wb_dat <= {24'h0, status};
        `I2C_ADDR_CLOCK_RATE:    o_wb_dat <= `I2C_CLOCK_RATE;
        `I2C_ADDR_CLOCK_DIVIDER: o_wb_dat <= {16'h0, divider};
        `I2C_ADDR_COMMAND:       o_wb_dat <= {27'h0, cmd};
        `I2C_ADDR_TRANSMIT:      o_wb_dat <= {24'h0, tx_byte};
        `I2C_ADDR_RECEIVE:       o_wb_dat <= {24'h0, cmd_bus.rx_byte};
        default:                 o_wb_dat <= 32'h0;
      endcase
    end
  end

  // control and divider, one-shot bits last a single cycle
  always_ff @(posedge clk) begin
    if (core_reset) begin
      ctrl    <= `I2C_CONTROL_RESET;
      divider <= `I2C_CLK_DIVIDE_100KHZ;
    end else begin
      if (ctrl.set_100khz) begin
        divider <= `I2C_CLK_DIVIDE_100KHZ;
      end
      if (ctrl.set_400khz) begin
        divider <= `I2C_CLK_DIVIDE_400KHZ;
      end
      ctrl.set_100khz <= 1'b0;
      ctrl.set_400khz <= 1'b0;
      ctrl.soft_reset <= 1'b0;
      if (wb_wr && i_wb_adr == `I2C_ADDR_CONTROL) begin
        ctrl <= i_wb_dat[7:0];
      end
      if (wb_wr && i_wb_adr == `I2C_ADDR_CLOCK_DIVIDER) begin
        divider <= i_wb_dat[15:0];
      end
    end
  end

  // command bits stay up until the byte controller finishes or loses the bus
  always_ff @(posedge clk) begin
    if (core_reset) begin
      cmd <= '0;
    end else begin
      if (cmd_bus.done || cmd_bus.al || ctrl.soft_reset) begin
        cmd.start <= 1'b0;
        cmd.stop  <= 1'b0;
        cmd.read  <= 1'b0;
        cmd.write <= 1'b0;
      end
      if (wb_wr && i_wb_adr == `I2C_ADDR_COMMAND) begin
        cmd <= i_wb_dat[4:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_wr && i_wb_adr == `I2C_ADDR_TRANSMIT) begin
      tx_byte <= i_wb_dat[7:0];
    end
  end

  // status flags and interrupt
  always_ff @(posedge clk) begin
    if (core_reset) begin
      rxack    <= 1'b0;
      tip      <= 1'b0;
      irq_flag <= 1'b0;
      al_seen  <= 1'b0;
      o_int    <= 1'b0;
    end else begin
      rxack    <= cmd_bus.rx_ack;
      tip      <= cmd.read | cmd.write;
      // lost arbitration sticks until the next start
      al_seen  <= cmd_bus.al | (al_seen & ~cmd.start);
      irq_flag <= cmd_bus.done | cmd_bus.al | (irq_flag & ~wb_req);
      o_int    <= irq_flag & ctrl.ien;
    end
  end

  always_comb begin
    status          = '0;
    status.rxack    = rxack;
    status.busy     = cmd_bus.busy;
    status.al       = al_seen;
    status.tip      = tip;
    status.irq_flag = irq_flag;
  end

  assign cmd_bus.cmd        = cmd;
  assign cmd_bus.tx_byte    = tx_byte;
  assign cmd_bus.divider    = divider;
  assign cmd_bus.core_en    = ctrl.core_en;
  assign cmd_bus.soft_reset = ctrl.soft_reset;

endmodule

// ==== hw/i2c_byte_ctrl.sv ====
`timescale 1ns/1ps

module i2c_byte_ctrl (
  input  logic      clk,
  input  logic      core_reset,
  i2c_cmd_if.slave  cmd_bus,
  i2c_bit_if.master bit_bus
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_ACK,
    ST_STOP
  } state_e;

  state_e                   state;
  i2c_wb_pkg::i2c_bit_cmd_e bit_cmd;
  i2c_wb_pkg::i2c_bit_cmd_e data_cmd;
  logic [7:0]               shreg;
  logic [2:0]               bit_cnt;
  logic                     bit_din;
  logic                     done;
  logic                     rx_ack;
  logic                     rst;
  logic                     go;

  assign rst = core_reset | cmd_bus.soft_reset;

  // done blocks a restart while the register block clears the command
  assign go = cmd_bus.core_en & ~done &
              (cmd_bus.cmd.start | cmd_bus.cmd.stop | cmd_bus.cmd.read | cmd_bus.cmd.write);

  assign data_cmd = cmd_bus.cmd.write ? i2c_wb_pkg::BIT_WRITE : i2c_wb_pkg::BIT_READ;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      bit_cmd <= i2c_wb_pkg::BIT_IDLE;
      bit_cnt <= 3'd0;
      done    <= 1'b0;
      rx_ack  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (bit_bus.al) begin
        state   <= ST_IDLE;
        bit_cmd <= i2c_wb_pkg::BIT_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            if (go) begin
              bit_cnt <= 3'd0;
              shreg   <= cmd_bus.tx_byte;
              bit_din <= cmd_bus.tx_byte[7];
              if (cmd_bus.cmd.start) begin
                state   <= ST_START;
                bit_cmd <= i2c_wb_pkg::BIT_START;
              end else if (cmd_bus.cmd.read || cmd_bus.cmd.write) begin
                state   <= ST_DATA;
                bit_cmd <= data_cmd;
              end else begin
                state   <= ST_STOP;
                bit_cmd <= i2c_wb_pkg::BIT_STOP;
              end
            end
          end
          ST_START: begin
            if (bit_bus.bit_ack) begin
              if (cmd_bus.cmd.read || cmd_bus.cmd.write) begin
                state   <= ST_DATA;
                bit_cmd <= data_cmd;
              end else if (cmd_bus.cmd.stop) begin
                state   <= ST_STOP;
                bit_cmd <= i2c_wb_pkg::BIT_STOP;
              end else begin
                state   <= ST_IDLE;
                bit_cmd <= i2c_wb_pkg::BIT_IDLE;
                done    <= 1'b1;
              end
            end
          end
          ST_DATA: begin
            // msb first, read data shifts in from the bottom
            if (bit_bus.bit_ack) begin
              shreg   <= {shreg[6:0], bit_bus.bit_dout};
              bit_din <= shreg[6];
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7) begin
                state <= ST_ACK;
                if (cmd_bus.cmd.read) begin
                  bit_cmd <= i2c_wb_pkg::BIT_WRITE;
                  bit_din <= cmd_bus.cmd.ack;
                end else begin
                  bit_cmd <= i2c_wb_pkg::BIT_READ;
                end
              end
            end
          end
          ST_ACK: begin
            if (bit_bus.bit_ack) begin
              if (cmd_bus.cmd.write) begin
                rx_ack <= bit_bus.bit_dout;
              end
              if (cmd_bus.cmd.stop) begin
                state   <= ST_STOP;
                bit_cmd <= i2c_wb_pkg::BIT_STOP;
              end else begin
                state   <= ST_IDLE;
                bit_cmd <= i2c_wb_pkg::BIT_IDLE;
                done    <= 1'b1;
              end
            end
          end
          ST_STOP: begin
            if (bit_bus.bit_ack) begin
              state   <= ST_IDLE;
              bit_cmd <= i2c_wb_pkg::BIT_IDLE;
              done    <= 1'b1;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  assign bit_bus.bit_cmd    = bit_cmd;
  assign bit_bus.bit_din    = bit_din;
  assign bit_bus.divider    = cmd_bus.divider;
  assign bit_bus.soft_reset = cmd_bus.soft_reset;

  assign cmd_bus.done    = done;
  assign cmd_bus.rx_ack  = rx_ack;
  assign cmd_bus.rx_byte = shreg;
  assign cmd_bus.busy    = bit_bus.busy;
  assign cmd_bus.al      = bit_bus.al;

endmodule

// ==== hw/i2c_bit_ctrl.sv ====
`timescale 1ns/1ps

module i2c_bit_ctrl (
  input  logic     clk,
  input  logic     core_reset,
  i2c_bit_if.slave bit_bus,
  input  logic     i_scl,
  input  logic     i_sda,
  output logic     o_scl_oe,
  output logic     o_sda_oe
);

  i2c_wb_pkg::i2c_bit_cmd_e op;
  logic [1:0]               scl_sync;
  logic [2:0]               sda_sync;
  logic [15:0]              cnt;
  logic [1:0]               phase;
  logic                     active;
  logic                     din_q;
  logic                     rst;
  logic                     scl_s;
  logic                     sda_s;
  logic                     sda_d;
  logic                     start_det;
  logic                     stop_det;
  logic                     stall;
  logic                     phase_end;
  logic                     sda_chk;
  logic                     al_cond;
  logic                     scl_lvl;
  logic                     sda_lvl;

  assign rst = core_reset | bit_bus.soft_reset;

  // two-flop synchronizers, idle bus reads high
  always_ff @(posedge clk) begin
    if (rst) begin
      scl_sync <= 2'b11;
      sda_sync <= 3'b111;
    end else begin
      scl_sync <= {scl_sync[0], i_scl};
      sda_sync <= {sda_sync[1:0], i_sda};
    end
  end

  assign scl_s = scl_sync[1];
  assign sda_s = sda_sync[1];
  assign sda_d = sda_sync[2];

  // sda edges while scl is high
  assign start_det = scl_s & sda_d & ~sda_s;
  assign stop_det  = scl_s & ~sda_d & sda_s;

  // scl released but still low, slave is stretching
  assign stall     = ~o_scl_oe & ~scl_s;
  assign phase_end = active & ~stall & (cnt == 16'd0);

  // sda released while scl high must read back high
  assign sda_chk = active & ~o_sda_oe & scl_s & ~sda_s &
                   (((op == i2c_wb_pkg::BIT_WRITE) && (phase == 2'd1 || phase == 2'd2)) ||
                    ((op == i2c_wb_pkg::BIT_START) && (phase == 2'd1)));
  assign al_cond = sda_chk | (active & stop_det & (op != i2c_wb_pkg::BIT_STOP));

  // line levels per quarter, 1 means released
  always_comb begin
    scl_lvl = ~o_scl_oe;
    sda_lvl = ~o_sda_oe;
    case (op)
      i2c_wb_pkg::BIT_START: begin
        // scl kept as is in the first quarter
        sda_lvl = (phase != 2'd2) && (phase != 2'd3);
        if (phase != 2'd0) begin
          scl_lvl = (phase != 2'd3);
        end
      end
      i2c_wb_pkg::BIT_STOP: begin
        scl_lvl = (phase != 2'd0);
        sda_lvl = phase[1];
      end
      i2c_wb_pkg::BIT_WRITE: begin
        scl_lvl = (phase == 2'd1) || (phase == 2'd2);
        sda_lvl = din_q;
      end
      i2c_wb_pkg::BIT_READ: begin
        scl_lvl = (phase == 2'd1) || (phase == 2'd2);
        sda_lvl = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      active           <= 1'b0;
      op               <= i2c_wb_pkg::BIT_IDLE;
      phase            <= 2'd0;
      cnt              <= 16'd0;
      bit_bus.bit_ack  <= 1'b0;
      bit_bus.al       <= 1'b0;
      bit_bus.busy     <= 1'b0;
      o_scl_oe         <= 1'b0;
      o_sda_oe         <= 1'b0;
    end else begin
      bit_bus.bit_ack <= 1'b0;
      bit_bus.al      <= al_cond;
      bit_bus.busy    <= (start_det | bit_bus.busy) & ~stop_det;
      if (al_cond) begin
        // give the bus up
        active   <= 1'b0;
        o_scl_oe <= 1'b0;
        o_sda_oe <= 1'b0;
      end else if (!active) begin
        if (bit_bus.bit_cmd != i2c_wb_pkg::BIT_IDLE && !bit_bus.bit_ack && !bit_bus.al) begin
          active <= 1'b1;
          op     <= bit_bus.bit_cmd;
          din_q  <= bit_bus.bit_din;
          phase  <= 2'd0;
          cnt    <= bit_bus.divider;
        end
      end else begin
        o_scl_oe <= ~scl_lvl;
        o_sda_oe <= ~sda_lvl;
        if (phase_end) begin
          cnt   <= bit_bus.divider;
          phase <= phase + 2'd1;
          if (phase == 2'd3) begin
            active          <= 1'b0;
            bit_bus.bit_ack <= 1'b1;
          end
        end else if (!stall) begin
          cnt <= cnt - 16'd1;
        end
      end
    end
  end

  // sample data at the end of the scl high time
  always_ff @(posedge clk) begin
    if (phase_end && phase == 2'd2) begin
      bit_bus.bit_dout <= sda_s;
    end
  end

endmodule

// ==== hw/i2c_wb_top.sv ====
`timescale 1ns/1ps

module i2c_wb_top (
  input  logic        clk,
  input  logic        core_reset,
  input  logic        i_wb_cyc,
  input  logic        i_wb_stb,
  input  logic        i_wb_we,
  input  logic [31:0] i_wb_adr,
  input  logic [31:0] i_wb_dat,
  output logic [31:0] o_wb_dat,
  output logic        o_wb_ack,
  output logic        o_int,
  input  logic        i_scl,
  input  logic        i_sda,
  output logic        o_scl_oe,
  output logic        o_sda_oe
);

  i2c_cmd_if cmd_bus ();
  i2c_bit_if bit_bus ();

  i2c_wb_regs u_regs (
    .clk        (clk),
    .core_reset (core_reset),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .o_wb_dat   (o_wb_dat),
    .o_wb_ack   (o_wb_ack),
    .o_int      (o_int),
    .cmd_bus    (cmd_bus.master)
  );

  i2c_byte_ctrl u_byte (
    .clk        (clk),
    .core_reset (core_reset),
    .cmd_bus    (cmd_bus.slave),
    .bit_bus    (bit_bus.master)
  );

  i2c_bit_ctrl u_bit (
    .clk        (clk),
    .core_reset (core_reset),
    .bit_bus    (bit_bus.slave),
    .i_scl      (i_scl),
    .i_sda      (i_sda),
    .o_scl_oe   (o_scl_oe),
    .o_sda_oe   (o_sda_oe)
  );

endmodule

// ==== verif/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model #(
  parameter logic [6:0] ADDR      = 7'h50,
  parameter logic [7:0] READ_BYTE = 8'h00
) (
  input  logic       i_scl,
  input  logic       i_sda,
  output logic       o_sda_oe,
  output logic [7:0] o_last_byte
);

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_WRITE, S_READ} state_e;

  state_e      state = S_IDLE;
  logic [7:0]  shreg = 8'h00;
  int unsigned bit_cnt = 0;
  logic        master_nack = 1'b0;
  logic        scl_q = 1'b1;
  logic        sda_q = 1'b1;

  initial begin
    o_sda_oe    = 1'b0;
    o_last_byte = 8'h00;
  end

  // one process tracks both lines, edges found against the last levels
  always @(i_scl or i_sda) begin
    if (scl_q === 1'b1 && i_scl === 1'b1 && sda_q === 1'b1 && i_sda === 1'b0) begin
      state    = S_ADDR;
      bit_cnt  = 0;
      o_sda_oe = 1'b0;
    end else if (scl_q === 1'b1 && i_scl === 1'b1 && sda_q === 1'b0 && i_sda === 1'b1) begin
      state    = S_IDLE;
      o_sda_oe = 1'b0;
    end else if (scl_q === 1'b0 && i_scl === 1'b1 && state != S_IDLE) begin
      if (state != S_READ && bit_cnt < 8) begin
        shreg = {shreg[6:0], i_sda};
      end
      if (state == S_READ && bit_cnt == 8) begin
        master_nack = i_sda;
      end
      bit_cnt = bit_cnt + 1;
    end else if (scl_q === 1'b1 && i_scl === 1'b0 && state != S_IDLE) begin
      if (state == S_READ) begin
        if (bit_cnt < 8) begin
          o_sda_oe = ~READ_BYTE[3'(7 - bit_cnt)];
        end else if (bit_cnt == 8) begin
          o_sda_oe = 1'b0;
        end else begin
          bit_cnt  = 0;
          o_sda_oe = master_nack ? 1'b0 : ~READ_BYTE[7];
          state    = master_nack ? S_IDLE : S_READ;
        end
      end else if (bit_cnt == 8) begin
        // acknowledge the address on a match, always the data
        if (state == S_WRITE) begin
          o_last_byte = shreg;
          o_sda_oe    = 1'b1;
        end else if (shreg[7:1] == ADDR) begin
          o_sda_oe = 1'b1;
        end else begin
          state = S_IDLE;
        end
      end else if (bit_cnt == 9) begin
        o_sda_oe = 1'b0;
        bit_cnt  = 0;
        if (state == S_ADDR && shreg[0]) begin
          state    = S_READ;
          o_sda_oe = ~READ_BYTE[7];
        end else begin
          state = S_WRITE;
        end
      end
    end
    scl_q = i_scl;
    sda_q = i_sda;
  end

endmodule

// ==== verif/i2c_wb_assertions.sv ====
`timescale 1ns/1ps

module i2c_wb_assertions (
  input logic clk,
  input logic core_reset,
  input logic i_wb_cyc,
  input logic i_wb_stb,
  input logic o_wb_ack,
  input logic o_scl_oe,
  input logic o_sda_oe
);

  int unsigned fail_count = 0;

  ack_one_cycle: assert property (@(posedge clk) disable iff (core_reset)
    o_wb_ack |=> !o_wb_ack)
    else begin
      fail_count = fail_count + 1;
      $error("wishbone ack held longer than one cycle");
    end

  ack_after_request: assert property (@(posedge clk) disable iff (core_reset)
    o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else begin
      fail_count = fail_count + 1;
      $error("wishbone ack without cyc and stb");
    end

  // lines released while held in reset
  lines_free_in_reset: assert property (@(posedge clk)
    core_reset |=> (!o_scl_oe && !o_sda_oe))
    else begin
      fail_count = fail_count + 1;
      $error("i2c line pulled low during reset");
    end

endmodule

// ==== verif/i2c_wb_tb.sv ====
`timescale 1ns/1ps
`include "i2c_wb_consts.svh"

module i2c_wb_tb;

  localparam int OP_WRITE = 0;
  localparam int OP_READ  = 1;
  localparam int OP_POLL  = 2;
  localparam int OP_SLAVE = 3;
  localparam int WAIT_LIMIT = 100;
  localparam int POLL_LIMIT = 2000;
  localparam logic [7:0] SLAVE_READ_BYTE = 8'hC5;

  logic        clk = 1'b0;
  logic        core_reset = 1'b1;
  logic        wb_cyc = 1'b0;
  logic        wb_stb = 1'b0;
  logic        wb_we = 1'b0;
  logic [31:0] wb_adr = 32'h0;
  logic [31:0] wb_dat = 32'h0;
  logic [31:0] o_wb_dat;
  logic        o_wb_ack;
  logic        o_int;
  logic        scl_oe;
  logic        sda_oe;
  wire         slave_sda_oe;
  wire  [7:0]  slave_byte;
  wire         scl;
  wire         sda;

  int          errors = 0;
  int          row_op[$];
  logic [31:0] row_adr[$];
  logic [31:0] row_dat[$];
  logic [31:0] row_exp[$];
  logic [31:0] rd_data;
  logic [7:0]  rnd_byte;
  int          n;
  i2c_wb_pkg::i2c_status_t st;

  always #2 clk = ~clk;

  // open-drain wiring, a line is high unless someone pulls it
  assign scl = ~scl_oe;
  assign sda = ~(sda_oe | slave_sda_oe);

  i2c_wb_top u_dut (
    .clk(clk), .core_reset(core_reset),
    .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
    .i_wb_adr(wb_adr), .i_wb_dat(wb_dat), .o_wb_dat(o_wb_dat),
    .o_wb_ack(o_wb_ack), .o_int(o_int),
    .i_scl(scl), .i_sda(sda), .o_scl_oe(scl_oe), .o_sda_oe(sda_oe)
  );

  i2c_slave_model #(.ADDR(7'h50), .READ_BYTE(SLAVE_READ_BYTE)) u_slave (
    .i_scl(scl), .i_sda(sda), .o_sda_oe(slave_sda_oe), .o_last_byte(slave_byte)
  );

  bind i2c_wb_top i2c_wb_assertions u_assertions (
    .clk(clk), .core_reset(core_reset), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
    .o_wb_ack(o_wb_ack), .o_scl_oe(o_scl_oe), .o_sda_oe(o_sda_oe)
  );

  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    int cnt;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    cnt = 0;
    while (!o_wb_ack && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!o_wb_ack) begin
      errors++;
      $display("no Wishbone acknowledge for address %0d within %0d cycles", adr, WAIT_LIMIT);
    end
    rdata  = o_wb_dat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // irq_flag depends on poll timing and is checked on its own
  task automatic check_status(input string what, input i2c_wb_pkg::i2c_status_t got,
                              input i2c_wb_pkg::i2c_status_t exp);
    if (got.rxack !== exp.rxack || got.busy !== exp.busy ||
        got.al !== exp.al || got.tip !== exp.tip) begin
      errors++;
      $display("error at %0t ns: %s status %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic poll_tip(output i2c_wb_pkg::i2c_status_t status);
    logic [31:0] word;
    int          cnt;
    word = 32'h2;
    cnt  = 0;
    while (word[1] && cnt < POLL_LIMIT) begin
      wb_access(1'b0, `I2C_ADDR_STATUS, 32'h0, word);
      cnt++;
    end
    if (word[1]) begin
      errors++;
      $display("transfer still in progress after %0d status polls", cnt);
    end
    status = word[7:0];
  endtask

  task automatic add_row(input int op, input logic [31:0] adr, input logic [31:0] dat,
                         input logic [31:0] exp);
    row_op.push_back(op);
    row_adr.push_back(adr);
    row_dat.push_back(dat);
    row_exp.push_back(exp);
  endtask

  initial begin
    void'($urandom(50));
    rnd_byte = 8'($urandom);
    // reset values, then presets and a fast divider
    add_row(OP_READ,  `I2C_ADDR_CONTROL, 0, {24'h0, `I2C_CONTROL_RESET});
    add_row(OP_READ,  `I2C_ADDR_CLOCK_DIVIDER, 0, {16'h0, `I2C_CLK_DIVIDE_100KHZ});
    add_row(OP_READ,  `I2C_ADDR_CLOCK_RATE, 0, `I2C_CLOCK_RATE);
    add_row(OP_READ,  `I2C_ADDR_STATUS, 0, 32'h0);
    add_row(OP_WRITE, `I2C_ADDR_CONTROL, 32'h09, 0);
    add_row(OP_READ,  `I2C_ADDR_CLOCK_DIVIDER, 0, {16'h0, `I2C_CLK_DIVIDE_400KHZ});
    add_row(OP_READ,  `I2C_ADDR_CONTROL, 0, 32'h01);
    add_row(OP_WRITE, `I2C_ADDR_CLOCK_DIVIDER, 32'd4, 0);
    add_row(OP_READ,  `I2C_ADDR_CLOCK_DIVIDER, 0, 32'd4);
    // addressed write with a random byte
    add_row(OP_WRITE, `I2C_ADDR_TRANSMIT, 32'hA0, 0);
    add_row(OP_WRITE, `I2C_ADDR_COMMAND, 32'h09, 0);
    add_row(OP_POLL,  0, 0, 32'h40);
    add_row(OP_WRITE, `I2C_ADDR_TRANSMIT, {24'h0, rnd_byte}, 0);
    add_row(OP_WRITE, `I2C_ADDR_COMMAND, 32'h0A, 0);
    add_row(OP_POLL,  0, 0, 32'h00);
    add_row(OP_SLAVE, 0, 0, {24'h0, rnd_byte});
    // read with a not-acknowledge and stop
    add_row(OP_WRITE, `I2C_ADDR_TRANSMIT, 32'hA1, 0);
    add_row(OP_WRITE, `I2C_ADDR_COMMAND, 32'h09, 0);
    add_row(OP_POLL,  0, 0, 32'h40);
    add_row(OP_WRITE, `I2C_ADDR_COMMAND, 32'h16, 0);
    add_row(OP_POLL,  0, 0, 32'h00);
    add_row(OP_READ,  `I2C_ADDR_RECEIVE, 0, {24'h0, SLAVE_READ_BYTE});
    // nobody answers at this address
    add_row(OP_WRITE, `I2C_ADDR_TRANSMIT, 32'hB0, 0);
    add_row(OP_WRITE, `I2C_ADDR_COMMAND, 32'h09, 0);
    add_row(OP_POLL,  0, 0, 32'hC0);

    repeat (8) @(negedge clk);
    core_reset = 1'b0;

    foreach (row_op[i]) begin
      case (row_op[i])
        OP_WRITE: wb_access(1'b1, row_adr[i], row_dat[i], rd_data);
        OP_READ: begin
          wb_access(1'b0, row_adr[i], 32'h0, rd_data);
          check_word($sformatf("row %0d", i), rd_data, row_exp[i]);
        end
        OP_POLL: begin
          poll_tip(st);
          check_status($sformatf("row %0d", i), st, row_exp[i][7:0]);
        end
        default: check_word($sformatf("row %0d slave byte", i), {24'h0, slave_byte}, row_exp[i]);
      endcase
    end

    // interrupt on a stop, cleared by any access
    wb_access(1'b1, `I2C_ADDR_CONTROL, 32'h03, rd_data);
    wb_access(1'b1, `I2C_ADDR_COMMAND, 32'h02, rd_data);
    n = 0;
    while (!o_int && n < POLL_LIMIT * 10) begin
      @(negedge clk);
      n++;
    end
    if (!o_int) begin
      errors++;
      $display("interrupt did not rise after the stop command");
    end
    wb_access(1'b0, `I2C_ADDR_CONTROL, 32'h0, rd_data);
    @(negedge clk);
    @(negedge clk);
    check_word("interrupt after read", {31'h0, o_int}, 32'h0);
    wb_access(1'b0, `I2C_ADDR_STATUS, 32'h0, rd_data);
    st = rd_data[7:0];
    check_word("status irq_flag", {31'h0, st.irq_flag}, 32'h0);

    $display("checks done: %0d errors, %0d assertion failures",
             errors, u_dut.u_assertions.fail_count);
    if (errors == 0 && u_dut.u_assertions.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== i2c_wb.f ====
+incdir+hw
hw/i2c_wb_pkg.sv
hw/i2c_wb_if.sv
hw/i2c_wb_regs.sv
hw/i2c_byte_ctrl.sv
hw/i2c_bit_ctrl.sv
hw/i2c_wb_top.sv
verif/i2c_slave_model.sv
verif/i2c_wb_assertions.sv
verif/i2c_wb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= i2c_wb_tb
FILELIST  ?= i2c_wb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

SRCS := $(wildcard hw/*.sv hw/*.svh verif/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | awk '{ print } index($$0, "$(PASS_TEXT)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
